//--- hdl/rv32i_pkg.sv
// RV32I front end types: data word, instruction field views and operation classes
package rv32i_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register format view
    // S and B immediates are also gathered from funct7 and rd here
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // Immediate format view, used for I, U and J layouts
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // One instruction word, two ways of reading it
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    // Operation classes seen by the back end
    typedef enum logic [3:0] {
        op_alu_reg,
        op_alu_imm,
        op_load,
        op_store,
        op_branch,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_illegal
    } op_class_e;

    // Base opcode map, low two bits always 2'b11
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

//--- hdl/fetch_stage.sv
// Fetch stage: walks the PC, requests words from instruction memory and fills the queue
`timescale 1ns/1ps

module fetch_stage #(
    parameter int               QUEUE_DEPTH = 8,
    parameter rv32i_pkg::word_t RESET_PC    = 32'h0000_1000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       redirect,
    input  rv32i_pkg::word_t           redirect_pc,
    input  rv32i_pkg::word_t           imem_rdata,
    input  logic [$clog2(QUEUE_DEPTH):0] q_count,
    output logic                       imem_req,
    output rv32i_pkg::word_t           imem_addr,
    output logic                       q_write,
    output rv32i_pkg::word_t           q_pc,
    output rv32i_pkg::word_t           q_next_pc,
    output rv32i_pkg::instr_t          q_instr
);
    import rv32i_pkg::*;

    localparam int CW = $clog2(QUEUE_DEPTH) + 1;

    word_t         pc;
    logic          running;
    logic          inflight_valid;
    logic          inflight_kill;
    word_t         inflight_pc;
    logic [CW-1:0] pending;

    // Entries already queued plus the one word still on its way back
    assign pending  = q_count + CW'(inflight_valid);
    assign imem_req = running && (pending < CW'(QUEUE_DEPTH));
    assign imem_addr = {pc[31:2], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= RESET_PC;
            running        <= 1'b0;
            inflight_valid <= 1'b0;
            inflight_kill  <= 1'b0;
        end else begin
            running        <= 1'b1;
            inflight_valid <= imem_req;
            // A request issued alongside a redirect fetches the old path
            inflight_kill  <= redirect;
            if (redirect) begin
                pc <= {redirect_pc[31:2], 2'b00};
            end else if (imem_req) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // PC of the word that memory returns next cycle
    always_ff @(posedge clk) begin
        if (imem_req) begin
            inflight_pc <= imem_addr;
        end
    end

    // Stale responses are dropped, and so is one landing on the flush itself
    assign q_write   = inflight_valid && !inflight_kill && !redirect;
    assign q_pc      = inflight_pc;
    assign q_next_pc = inflight_pc + 32'd4;
    assign q_instr   = imem_rdata;

    // Space rule keeps fetch from ever overrunning the queue
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        q_write |-> (q_count != CW'(QUEUE_DEPTH)));

endmodule

//--- hdl/i_queue.sv
// Instruction queue: first-word-fall-through circular buffer of PC, next PC and instruction
`timescale 1ns/1ps

module i_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         read,
    input  logic                         write,
    input  rv32i_pkg::word_t             in_pc,
    input  rv32i_pkg::word_t             in_next_pc,
    input  rv32i_pkg::instr_t            in_instr,
    output rv32i_pkg::word_t             head_pc,
    output rv32i_pkg::word_t             head_next_pc,
    output rv32i_pkg::instr_t            head_instr,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(QUEUE_DEPTH):0] count
);
    import rv32i_pkg::*;

    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam int CW = AW + 1;

    // Storage, one array per field
    word_t  pc_mem      [QUEUE_DEPTH];
    word_t  next_pc_mem [QUEUE_DEPTH];
    instr_t instr_mem   [QUEUE_DEPTH];

    logic [AW-1:0] head_ptr;
    logic [AW-1:0] tail_ptr;
    logic          rd_en;
    logic          wr_en;

    assign empty = (count == '0);
    assign full  = (count == CW'(QUEUE_DEPTH));

    assign rd_en = read && !empty;
    assign wr_en = write && !full;

    // Head entry straight out of the array
    assign head_pc      = pc_mem[head_ptr];
    assign head_next_pc = next_pc_mem[head_ptr];
    assign head_instr   = instr_mem[head_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (rd_en) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (wr_en) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // Pop and push together leave the count alone
            case ({rd_en, wr_en})
                2'b01:   count <= count + 1'b1;
                2'b10:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            pc_mem[tail_ptr]      <= in_pc;
            next_pc_mem[tail_ptr] <= in_next_pc;
            instr_mem[tail_ptr]   <= in_instr;
        end
    end

    // Decode must only pop a visible entry
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        read |-> !empty);

    // Fetch flow control must keep writes off a full queue
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        write |-> !full);

endmodule

//--- hdl/decode_stage.sv
// Decode stage: pops the queue, classifies the opcode and registers fields and immediate
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 q_empty,
    input  rv32i_pkg::word_t     q_head_pc,
    input  rv32i_pkg::word_t     q_head_next_pc,
    input  rv32i_pkg::instr_t    q_head_instr,
    output logic                 q_read,
    output logic                 dec_valid,
    output rv32i_pkg::word_t     dec_pc,
    output rv32i_pkg::word_t     dec_next_pc,
    output rv32i_pkg::op_class_e dec_op,
    output logic [4:0]           dec_rd,
    output logic [4:0]           dec_rs1,
    output logic [4:0]           dec_rs2,
    output logic [2:0]           dec_funct3,
    output rv32i_pkg::word_t     dec_imm
);
    import rv32i_pkg::*;

    r_fields_t  rf;
    i_fields_t  xf;
    op_class_e  op_d;
    logic [4:0] rs2_d;
    word_t      imm_d;

    assign rf = q_head_instr.r;
    assign xf = q_head_instr.i;

    assign q_read = !q_empty && !stall;

    // Opcode to class
    always_comb begin
        case (rf.opcode)
            OPC_OP:     op_d = op_alu_reg;
            OPC_OP_IMM: op_d = op_alu_imm;
            OPC_LOAD:   op_d = op_load;
            OPC_STORE:  op_d = op_store;
            OPC_BRANCH: op_d = op_branch;
            OPC_LUI:    op_d = op_lui;
            OPC_AUIPC:  op_d = op_auipc;
            OPC_JAL:    op_d = op_jal;
            OPC_JALR:   op_d = op_jalr;
            default:    op_d = op_illegal;
        endcase
    end

    // rs2 and immediate by class
    always_comb begin
        rs2_d = '0;
        imm_d = '0;
        case (op_d)
            op_alu_reg: rs2_d = rf.rs2;
            op_alu_imm, op_load, op_jalr: begin
                imm_d = {{20{xf.imm12[11]}}, xf.imm12};
            end
            op_store: begin
                rs2_d = rf.rs2;
                imm_d = {{20{rf.funct7[6]}}, rf.funct7, rf.rd};
            end
            op_branch: begin
                rs2_d = rf.rs2;
                // imm[12|10:5] in funct7, imm[4:1|11] in rd
                imm_d = {{19{rf.funct7[6]}}, rf.funct7[6], rf.rd[0],
                         rf.funct7[5:0], rf.rd[4:1], 1'b0};
            end
            op_lui, op_auipc: imm_d = {xf.imm12, xf.rs1, xf.funct3, 12'h000};
            op_jal: begin
                // imm[19:12] sits where rs1 and funct3 normally are
                imm_d = {{11{xf.imm12[11]}}, xf.imm12[11], xf.rs1, xf.funct3,
                         xf.imm12[0], xf.imm12[10:1], 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= q_read;
        end
    end

    // Payload only moves on a pop, so it holds under stall
    always_ff @(posedge clk) begin
        if (q_read) begin
            dec_pc      <= q_head_pc;
            dec_next_pc <= q_head_next_pc;
            dec_op      <= op_d;
            dec_rd      <= rf.rd;
            dec_rs1     <= rf.rs1;
            dec_rs2     <= rs2_d;
            dec_funct3  <= rf.funct3;
            dec_imm     <= imm_d;
        end
    end

    // Back end sees a frozen instruction for as long as it stalls
    a_hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && dec_valid && !flush) |=>
            $stable({dec_valid, dec_pc, dec_next_pc, dec_op, dec_rd,
                     dec_rs1, dec_rs2, dec_funct3, dec_imm}));

endmodule

//--- hdl/front_end.sv
// RV32I instruction front end: fetch, instruction queue and decode in a three-stage pipe
`timescale 1ns/1ps

module front_end #(
    parameter int               QUEUE_DEPTH = 8,
    parameter rv32i_pkg::word_t RESET_PC    = 32'h0000_1000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 redirect,
    input  rv32i_pkg::word_t     redirect_pc,
    input  rv32i_pkg::word_t     imem_rdata,
    output logic                 imem_req,
    output rv32i_pkg::word_t     imem_addr,
    output logic                 dec_valid,
    output rv32i_pkg::word_t     dec_pc,
    output rv32i_pkg::word_t     dec_next_pc,
    output rv32i_pkg::op_class_e dec_op,
    output logic [4:0]           dec_rd,
    output logic [4:0]           dec_rs1,
    output logic [4:0]           dec_rs2,
    output logic [2:0]           dec_funct3,
    output rv32i_pkg::word_t     dec_imm
);
    import rv32i_pkg::*;

    // Fetch to queue
    logic                         q_write;
    word_t                        q_pc;
    word_t                        q_next_pc;
    instr_t                       q_instr;
    logic [$clog2(QUEUE_DEPTH):0] q_count;

    // Queue to decode
    logic   q_read;
    logic   q_empty;
    word_t  q_head_pc;
    word_t  q_head_next_pc;
    instr_t q_head_instr;

    fetch_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rdata  (imem_rdata),
        .q_count     (q_count),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .q_write     (q_write),
        .q_pc        (q_pc),
        .q_next_pc   (q_next_pc),
        .q_instr     (q_instr)
    );

    // Full flag unused here, fetch works from the count
    i_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (redirect),
        .read         (q_read),
        .write        (q_write),
        .in_pc        (q_pc),
        .in_next_pc   (q_next_pc),
        .in_instr     (q_instr),
        .head_pc      (q_head_pc),
        .head_next_pc (q_head_next_pc),
        .head_instr   (q_head_instr),
        .empty        (q_empty),
        .full         (),
        .count        (q_count)
    );

    decode_stage u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (redirect),
        .stall          (stall),
        .q_empty        (q_empty),
        .q_head_pc      (q_head_pc),
        .q_head_next_pc (q_head_next_pc),
        .q_head_instr   (q_head_instr),
        .q_read         (q_read),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_next_pc    (dec_next_pc),
        .dec_op         (dec_op),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_funct3     (dec_funct3),
        .dec_imm        (dec_imm)
    );

endmodule

//--- testbench/front_end_tb.sv
// Front end testbench: memory model, reference decoder and directed fetch, queue and decode tests
`timescale 1ns/1ps

module front_end_tb;
    import rv32i_pkg::*;

    localparam int    QUEUE_DEPTH = 8;
    localparam word_t RESET_PC    = 32'h0000_1000;
    localparam int    MEM_WORDS   = 256;
    localparam int    TEST_CYCLES = 16 + 30 + 25 + (5 * QUEUE_DEPTH + 10)
                                  + (2 * QUEUE_DEPTH + 40) + 4;
    localparam int    TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    word_t     imem_rdata = '0;
    logic      imem_req;
    word_t     imem_addr;
    logic      dec_valid;
    word_t     dec_pc;
    word_t     dec_next_pc;
    op_class_e dec_op;
    logic [4:0] dec_rd;
    logic [4:0] dec_rs1;
    logic [4:0] dec_rs2;
    logic [2:0] dec_funct3;
    word_t     dec_imm;

    word_t        mem [MEM_WORDS];
    logic [31:0]  lfsr_state = 32'h69c7f92c;
    int           errors = 0;
    int           n_checked = 0;
    int           cycles = 0;
    int           flush_wait = 0;
    word_t        exp_pc = RESET_PC;
    logic         first_req_seen = 1'b0;
    logic         prev_stall = 1'b0;
    logic         prev_valid = 1'b0;
    logic [9:0]   class_seen = '0;
    logic         neg_seen = 1'b0;
    logic [117:0] dec_hold;
    logic [117:0] held = '0;

    assign dec_hold = {dec_pc, dec_next_pc, dec_op, dec_rd, dec_rs1, dec_rs2, dec_funct3, dec_imm};

    front_end #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rdata  (imem_rdata),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_next_pc (dec_next_pc),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_funct3  (dec_funct3),
        .dec_imm     (dec_imm)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t take_bits(input int n);
        word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_step()};
        end
        return val;
    endfunction

    // Memory window starts at the reset PC and wraps every 1 KB
    function automatic logic [7:0] mem_index(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        return off[9:2];
    endfunction

    function automatic logic [6:0] opcode_for(input int k);
        case (k)
            0:       return OPC_OP;
            1:       return OPC_OP_IMM;
            2:       return OPC_LOAD;
            3:       return OPC_STORE;
            4:       return OPC_BRANCH;
            5:       return OPC_LUI;
            6:       return OPC_AUIPC;
            7:       return OPC_JAL;
            8:       return OPC_JALR;
            default: return 7'b0001011;
        endcase
    endfunction

    function automatic op_class_e ref_op(input word_t w);
        case (w[6:0])
            OPC_OP:     return op_alu_reg;
            OPC_OP_IMM: return op_alu_imm;
            OPC_LOAD:   return op_load;
            OPC_STORE:  return op_store;
            OPC_BRANCH: return op_branch;
            OPC_LUI:    return op_lui;
            OPC_AUIPC:  return op_auipc;
            OPC_JAL:    return op_jal;
            OPC_JALR:   return op_jalr;
            default:    return op_illegal;
        endcase
    endfunction

    function automatic logic [4:0] ref_rs2(input word_t w, input op_class_e op);
        if (op == op_alu_reg || op == op_store || op == op_branch) begin
            return w[24:20];
        end
        return 5'd0;
    endfunction

    // Immediate layouts straight from the RV32I encoding tables
    function automatic word_t ref_imm(input word_t w, input op_class_e op);
        case (op)
            op_alu_imm, op_load, op_jalr: return {{20{w[31]}}, w[31:20]};
            op_store:         return {{20{w[31]}}, w[31:25], w[11:7]};
            op_branch:        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            op_lui, op_auipc: return {w[31:12], 12'h000};
            op_jal:           return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:          return 32'h0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_output();
        word_t     w;
        word_t     imm;
        op_class_e op;
        w   = mem[mem_index(exp_pc)];
        op  = ref_op(w);
        imm = ref_imm(w, op);
        check_word("dec_pc", dec_pc, exp_pc);
        check_word("dec_next_pc", dec_next_pc, exp_pc + 32'd4);
        check_word("dec_op", 32'(dec_op), 32'(op));
        check_word("dec_rd", 32'(dec_rd), 32'(w[11:7]));
        check_word("dec_rs1", 32'(dec_rs1), 32'(w[19:15]));
        check_word("dec_rs2", 32'(dec_rs2), 32'(ref_rs2(w, op)));
        check_word("dec_funct3", 32'(dec_funct3), 32'(w[14:12]));
        check_word("dec_imm", dec_imm, imm);
        // Classes and signs as the DUT reported them
        class_seen[dec_op] = 1'b1;
        if (dec_imm[31] && dec_op != op_lui && dec_op != op_auipc) begin
            neg_seen = 1'b1;
        end
        exp_pc = exp_pc + 32'd4;
        n_checked++;
    endtask

    // Instruction memory with one cycle of read latency
    always @(posedge clk) begin
        if (imem_req) begin
            imem_rdata <= mem[mem_index(imem_addr)];
        end
    end

    // Output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (imem_req && !first_req_seen) begin
                first_req_seen = 1'b1;
                check_word("imem_addr", imem_addr, RESET_PC);
            end
            if (flush_wait > 0) begin
                assert (!dec_valid) else begin
                    errors++;
                    $display("dec_valid came back within two cycles of a redirect");
                end
                flush_wait--;
            end
            if (dec_valid && !prev_stall) begin
                check_output();
            end else if (dec_valid && prev_valid) begin
                assert (dec_hold === held) else begin
                    errors++;
                    $display("Mismatch dec outputs under stall: got %h, expected %h",
                             dec_hold, held);
                end
            end
            // Old path may still finish this cycle, new path starts after the edge
            if (redirect) begin
                exp_pc     = redirect_pc;
                flush_wait = 2;
            end
            prev_stall = stall;
            prev_valid = dec_valid;
            held       = dec_hold;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic fill_memory();
        word_t r;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = take_bits(25);
            mem[i] = {r[24:0], opcode_for(i % 10)};
        end
    endtask

    task automatic wait_outputs(input int n);
        int target;
        target = n_checked + n;
        while (n_checked < target) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_redirect(input word_t target);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic test_reset();
        repeat (16) begin
            @(negedge clk);
            assert (!imem_req && !dec_valid) else begin
                errors++;
                $display("imem_req or dec_valid high during reset");
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!imem_req && !dec_valid) else begin
            errors++;
            $display("imem_req or dec_valid high right after reset");
        end
        while (!first_req_seen) begin
            @(posedge clk);
        end
    endtask

    task automatic test_stream();
        wait_outputs(24);
    endtask

    task automatic test_classes();
        class_seen = '0;
        neg_seen   = 1'b0;
        wait_outputs(20);
        assert (class_seen == 10'h3ff && neg_seen) else begin
            errors++;
            $display("Not every operation class or no negative immediate was decoded");
        end
    endtask

    task automatic test_stall();
        wait_outputs(2);
        @(posedge clk);
        stall <= 1'b1;
        repeat (3 * QUEUE_DEPTH) @(posedge clk);
        @(negedge clk);
        assert (!imem_req) else begin
            errors++;
            $display("Fetch kept requesting while the queue was full");
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_outputs(2 * QUEUE_DEPTH);
    endtask

    task automatic test_redirect();
        word_t target;
        wait_outputs(3);
        target = RESET_PC + (take_bits(8) << 2);
        pulse_redirect(target);
        wait_outputs(6);
        @(posedge clk);
        stall <= 1'b1;
        repeat (4) @(posedge clk);
        target = RESET_PC + (take_bits(8) << 2);
        pulse_redirect(target);
        repeat (2 * QUEUE_DEPTH) @(posedge clk);
        stall <= 1'b0;
        wait_outputs(6);
    endtask

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        fill_memory();
        test_reset();
        test_stream();
        test_classes();
        test_stall();
        test_redirect();
        repeat (4) @(posedge clk);
        $display("Errors: %0d, instructions checked: %0d", errors, n_checked);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/rv32i_pkg.sv
hdl/fetch_stage.sv
hdl/i_queue.sv
hdl/decode_stage.sv
hdl/front_end.sv
testbench/front_end_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the front end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module front_end_tb -f list.f -o front_end_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/front_end_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
